//--- flist.f
source/elevator_pkg.sv
source/request_register.sv
source/target_selector.sv
source/car_control.sv
source/floor_logic_top.sv
tb/floor_logic_props.sv
tb/floor_logic_tb.sv

//--- source/car_control.sv
`timescale 1ns/10ps

module car_control
    import elevator_pkg::*;
(
    input  logic   clock,
    input  logic   reset_n,
    input  floor_t target_floor,
    input  floor_t current_floor_state,
    input  logic   power_switch,
    input  logic   emergency_btn,
    input  logic   elevator_moving,
    input  logic   door_open_btn,
    input  logic   door_close_btn,
    output logic   activate_elevator,
    output logic   direction_selector,
    output logic   door_open_allowed,
    output logic   door_close_allowed
);

    logic start_travel;
    logic doors_enabled;

    //////////////////////////////
    // Travel command
    //////////////////////////////

    // Only a stopped, powered car with somewhere to go is sent off
    assign start_travel = power_switch && !emergency_btn && !elevator_moving &&
                          (target_floor != current_floor_state);

    // Direction holds between trips and feeds the selector's scan order
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            activate_elevator  <= 1'b0;
            direction_selector <= 1'b0;
        end else begin
            activate_elevator <= start_travel;
            if (start_travel) begin
                direction_selector <= (target_floor > current_floor_state);
            end
        end
    end

    //////////////////////////////
    // Door permission
    //////////////////////////////

    assign doors_enabled = !elevator_moving && power_switch;

    // Buttons pass through only while stopped and powered, else both drop low
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            door_open_allowed  <= doors_enabled && door_open_btn;
            door_close_allowed <= doors_enabled && door_close_btn;
        end
    end

endmodule

//--- source/elevator_pkg.sv
package elevator_pkg;

    //////////////////////////////
    // Building size
    //////////////////////////////

    // Served floors, floor 1 up to floor 11
    localparam int num_floors = 11;

    //////////////////////////////
    // Floor types
    //////////////////////////////

    // Floor code, code 0 is floor 1 and code 10 is floor 11
    typedef logic [3:0] floor_t;

    // One request bit per floor, bit i stands for floor code i
    typedef logic [num_floors-1:0] floor_mask_t;

    //////////////////////////////
    // Floor codes
    //////////////////////////////

    // Lowest and highest valid codes
    localparam floor_t floor_first = 4'd0;
    localparam floor_t floor_last  = 4'd10;

endpackage

//--- source/floor_logic_top.sv
`timescale 1ns/10ps

module floor_logic_top
    import elevator_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    input  floor_mask_t floor_call_buttons,
    input  floor_mask_t panel_buttons,
    input  logic        door_open_btn,
    input  logic        door_close_btn,
    input  logic        emergency_btn,
    input  logic        power_switch,
    input  floor_t      current_floor_state,
    input  logic        elevator_moving,
    output floor_mask_t call_button_lights,
    output floor_mask_t panel_button_lights,
    output floor_t      elevator_floor_selector,
    output logic        direction_selector,
    output logic        activate_elevator,
    output logic        door_open_allowed,
    output logic        door_close_allowed
);

    //////////////////////////////
    // Request stage
    //////////////////////////////

    // Hall call buttons
    request_register call_bank (
        .clock               (clock),
        .reset_n             (reset_n),
        .buttons             (floor_call_buttons),
        .power_switch        (power_switch),
        .emergency_btn       (emergency_btn),
        .elevator_moving     (elevator_moving),
        .current_floor_state (current_floor_state),
        .lights              (call_button_lights)
    );

    // Car panel buttons
    request_register panel_bank (
        .clock               (clock),
        .reset_n             (reset_n),
        .buttons             (panel_buttons),
        .power_switch        (power_switch),
        .emergency_btn       (emergency_btn),
        .elevator_moving     (elevator_moving),
        .current_floor_state (current_floor_state),
        .lights              (panel_button_lights)
    );

    //////////////////////////////
    // Target stage
    //////////////////////////////

    // Last travel direction comes back from the control stage
    target_selector selector (
        .clock               (clock),
        .reset_n             (reset_n),
        .call_lights         (call_button_lights),
        .panel_lights        (panel_button_lights),
        .current_floor_state (current_floor_state),
        .elevator_moving     (elevator_moving),
        .direction_selector  (direction_selector),
        .target_floor        (elevator_floor_selector)
    );

    //////////////////////////////
    // Control stage
    //////////////////////////////

    car_control control (
        .clock               (clock),
        .reset_n             (reset_n),
        .target_floor        (elevator_floor_selector),
        .current_floor_state (current_floor_state),
        .power_switch        (power_switch),
        .emergency_btn       (emergency_btn),
        .elevator_moving     (elevator_moving),
        .door_open_btn       (door_open_btn),
        .door_close_btn      (door_close_btn),
        .activate_elevator   (activate_elevator),
        .direction_selector  (direction_selector),
        .door_open_allowed   (door_open_allowed),
        .door_close_allowed  (door_close_allowed)
    );

endmodule

//--- source/request_register.sv
`timescale 1ns/10ps

module request_register
    import elevator_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    input  floor_mask_t buttons,
    input  logic        power_switch,
    input  logic        emergency_btn,
    input  logic        elevator_moving,
    input  floor_t      current_floor_state,
    output floor_mask_t lights
);

    floor_mask_t at_floor;
    floor_mask_t set_mask;
    floor_mask_t clear_mask;
    logic        accept_press;
    logic        standing;

    //////////////////////////////
    // Floor decode
    //////////////////////////////

    // One-hot mask of the floor the car is at
    always_comb begin
        for (int i = 0; i < num_floors; i++) begin
            at_floor[i] = (current_floor_state == floor_t'(i));
        end
    end

    //////////////////////////////
    // Set and clear rules
    //////////////////////////////

    assign accept_press = power_switch && !emergency_btn;
    assign standing     = power_switch && !elevator_moving;

    // A press at the standing floor never lights, so set and clear stay disjoint
    assign set_mask   = accept_press ? (buttons & ~at_floor) : '0;
    assign clear_mask = standing ? at_floor : '0;

    // All pressed buttons latch together, other lights keep their value
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lights <= '0;
        end else begin
            lights <= (lights & ~clear_mask) | set_mask;
        end
    end

endmodule

//--- source/target_selector.sv
`timescale 1ns/10ps

module target_selector
    import elevator_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    input  floor_mask_t call_lights,
    input  floor_mask_t panel_lights,
    input  floor_t      current_floor_state,
    input  logic        elevator_moving,
    input  logic        direction_selector,
    output floor_t      target_floor
);

    floor_mask_t pending;
    floor_t      nearest_above;
    floor_t      nearest_below;
    logic        found_above;
    logic        found_below;
    floor_t      next_target;
    logic        car_ready;

    // Hall calls and car calls are served alike
    assign pending = call_lights | panel_lights;

    //////////////////////////////
    // Scan above the car
    //////////////////////////////

    // Walk downward so the lowest pending floor above the car wins
    always_comb begin
        nearest_above = current_floor_state;
        found_above   = 1'b0;
        for (int i = floor_last; i >= int'(floor_first); i--) begin
            if (pending[i] && (floor_t'(i) > current_floor_state)) begin
                nearest_above = floor_t'(i);
                found_above   = 1'b1;
            end
        end
    end

    //////////////////////////////
    // Scan below the car
    //////////////////////////////

    // Walk upward so the highest pending floor below the car wins
    always_comb begin
        nearest_below = current_floor_state;
        found_below   = 1'b0;
        for (int i = floor_first; i <= floor_last; i++) begin
            if (pending[i] && (floor_t'(i) < current_floor_state)) begin
                nearest_below = floor_t'(i);
                found_below   = 1'b1;
            end
        end
    end

    //////////////////////////////
    // Direction ordering
    //////////////////////////////

    // Keep going the way the car last travelled, then turn around
    always_comb begin
        next_target = current_floor_state;
        if (direction_selector) begin
            if (found_above) begin
                next_target = nearest_above;
            end else if (found_below) begin
                next_target = nearest_below;
            end
        end else begin
            if (found_below) begin
                next_target = nearest_below;
            end else if (found_above) begin
                next_target = nearest_above;
            end
        end
    end

    // Car is idle or has reached the previous target
    assign car_ready = !elevator_moving && (target_floor == current_floor_state);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            target_floor <= floor_first;
        end else if (car_ready) begin
            target_floor <= next_target;
        end
    end

endmodule

//--- tb/floor_logic_props.sv
`timescale 1ns/10ps

module floor_logic_props
    import elevator_pkg::*;
(
    input logic   clock,
    input logic   reset_n,
    input logic   elevator_moving,
    input logic   power_switch,
    input logic   activate_elevator,
    input logic   door_open_allowed,
    input logic   door_close_allowed,
    input floor_t elevator_floor_selector
);

    // Count of failed assertions
    int assert_failures;

    //////////////////////////////
    // Control stage
    //////////////////////////////

    // No new travel command while the car was in motion
    assert property (@(posedge clock) disable iff (!reset_n)
        $past(elevator_moving) |-> !activate_elevator)
        else begin
            assert_failures++;
            $error("activate_elevator high one cycle after elevator_moving");
        end

    // Doors are locked out once power drops
    assert property (@(posedge clock) disable iff (!reset_n)
        !$past(power_switch) |-> (!door_open_allowed && !door_close_allowed))
        else begin
            assert_failures++;
            $error("door permission high one cycle after power_switch low");
        end

    //////////////////////////////
    // Target stage
    //////////////////////////////

    assert property (@(posedge clock) disable iff (!reset_n)
        elevator_floor_selector <= floor_last)
        else begin
            assert_failures++;
            $error("elevator_floor_selector beyond the top floor");
        end

endmodule

bind floor_logic_top floor_logic_props props (.*);

//--- tb/floor_logic_tb.sv
`timescale 1ns/10ps

module floor_logic_tb
    import elevator_pkg::*;
();

    logic        clock;
    logic        reset_n;
    floor_mask_t floor_call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_btn;
    logic        door_close_btn;
    logic        emergency_btn;
    logic        power_switch;
    floor_t      current_floor_state;
    logic        elevator_moving;
    floor_mask_t call_button_lights;
    floor_mask_t panel_button_lights;
    floor_t      elevator_floor_selector;
    logic        direction_selector;
    logic        activate_elevator;
    logic        door_open_allowed;
    logic        door_close_allowed;

    // Predicted output registers
    floor_mask_t exp_call;
    floor_mask_t exp_panel;
    floor_t      exp_target;
    logic        exp_activate;
    logic        exp_direction;
    logic        exp_door_open;
    logic        exp_door_close;

    integer seed;
    int     error_count;
    int     timeout_count;
    int     trip_left;
    int     latency;
    int     steps;

    floor_logic_top UUT (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    //////////////////////////////
    // Checking
    //////////////////////////////

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %s at %0t: actual 0x%h, expected 0x%h",
                     name, $time, actual, expected);
        end
    endtask

    //////////////////////////////
    // Cycle model
    //////////////////////////////

    function automatic floor_mask_t next_lights(floor_mask_t lights, floor_mask_t buttons);
        floor_mask_t result;
        result = lights;
        for (int i = 0; i < num_floors; i++) begin
            if (buttons[i] && power_switch && !emergency_btn && current_floor_state != i) begin
                result[i] = 1'b1;
            end else if (power_switch && !elevator_moving && current_floor_state == i) begin
                result[i] = 1'b0;
            end
        end
        return result;
    endfunction

    // Search outward from the car, the closest hit on each side is kept
    function automatic floor_t pick_target(floor_mask_t pending, floor_t here, logic going_up);
        int h;
        int lo;
        int hi;
        int up_hit;
        int down_hit;
        h = here;
        lo = floor_first;
        hi = floor_last;
        up_hit = -1;
        down_hit = -1;
        for (int d = num_floors - 1; d >= 1; d--) begin
            if (h + d <= hi) begin
                if (pending[h + d]) up_hit = h + d;
            end
            if (h - d >= lo) begin
                if (pending[h - d]) down_hit = h - d;
            end
        end
        if (going_up) begin
            if (up_hit >= 0) return floor_t'(up_hit);
            if (down_hit >= 0) return floor_t'(down_hit);
        end else begin
            if (down_hit >= 0) return floor_t'(down_hit);
            if (up_hit >= 0) return floor_t'(up_hit);
        end
        return here;
    endfunction

    task automatic step_model();
        floor_t new_target;
        logic   start;
        new_target = exp_target;
        if (!elevator_moving && exp_target == current_floor_state) begin
            new_target = pick_target(exp_call | exp_panel, current_floor_state, exp_direction);
        end
        start = power_switch && !emergency_btn && !elevator_moving &&
                (exp_target != current_floor_state);
        if (start) begin
            exp_direction = (exp_target > current_floor_state);
        end
        exp_activate   = start;
        exp_door_open  = !elevator_moving && power_switch && door_open_btn;
        exp_door_close = !elevator_moving && power_switch && door_close_btn;
        exp_call       = next_lights(exp_call, floor_call_buttons);
        exp_panel      = next_lights(exp_panel, panel_buttons);
        exp_target     = new_target;
    endtask

    always @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            exp_call = '0;
            exp_panel = '0;
            exp_target = floor_first;
            exp_activate = 1'b0;
            exp_direction = 1'b0;
            exp_door_open = 1'b0;
            exp_door_close = 1'b0;
        end else begin
            step_model();
        end
    end

    // Outputs are settled at the falling edge
    always @(negedge clock) begin
        if (reset_n) begin
            compare_value("call_button_lights", call_button_lights, exp_call);
            compare_value("panel_button_lights", panel_button_lights, exp_panel);
            compare_value("elevator_floor_selector", elevator_floor_selector, exp_target);
            compare_value("activate_elevator", activate_elevator, exp_activate);
            compare_value("direction_selector", direction_selector, exp_direction);
            compare_value("door_open_allowed", door_open_allowed, exp_door_open);
            compare_value("door_close_allowed", door_close_allowed, exp_door_close);
        end
    end

    //////////////////////////////
    // Stimulus and motion
    //////////////////////////////

    function automatic bit coin(int odds);
        return ($unsigned($random(seed)) % odds) == 0;
    endfunction

    function automatic floor_mask_t random_press();
        floor_mask_t mask;
        mask = '0;
        if (coin(3)) begin
            mask[floor_first + $unsigned($random(seed)) % num_floors] = 1'b1;
        end
        return mask;
    endfunction

    // One clock of traffic plus the motion FSM stand-in
    task automatic run_cycle(input bit traffic);
        @(posedge clock);
        floor_call_buttons <= traffic ? random_press() : '0;
        panel_buttons      <= traffic ? random_press() : '0;
        door_open_btn      <= traffic && coin(3);
        door_close_btn     <= traffic && coin(3);
        emergency_btn      <= traffic && coin(20);
        power_switch       <= !(traffic && coin(20));
        if (trip_left > 0) begin
            trip_left--;
            if (current_floor_state < elevator_floor_selector) begin
                current_floor_state <= current_floor_state + 1'b1;
            end else if (current_floor_state > elevator_floor_selector) begin
                current_floor_state <= current_floor_state - 1'b1;
            end
            if (trip_left == 0) elevator_moving <= 1'b0;
        end else if (activate_elevator) begin
            trip_left = 2 + $unsigned($random(seed)) % 4;
            elevator_moving <= 1'b1;
        end
    endtask

    initial begin
        seed = 3;
        error_count = 0;
        timeout_count = 0;
        trip_left = 0;
        reset_n = 1'b0;
        floor_call_buttons = '0;
        panel_buttons = '0;
        door_open_btn = 1'b0;
        door_close_btn = 1'b0;
        emergency_btn = 1'b0;
        power_switch = 1'b1;
        current_floor_state = floor_first;
        elevator_moving = 1'b0;
        repeat (2) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);
        compare_value("call_button_lights", call_button_lights, 0);
        compare_value("panel_button_lights", panel_button_lights, 0);
        compare_value("activate_elevator", activate_elevator, 0);
        compare_value("direction_selector", direction_selector, 0);
        compare_value("door_open_allowed", door_open_allowed, 0);
        compare_value("door_close_allowed", door_close_allowed, 0);

        // Single car call to floor code 5 from an idle car at code 0
        @(posedge clock);
        panel_buttons <= floor_mask_t'(1) << 5;
        latency = 0;
        while (!activate_elevator && latency < 10) begin
            @(posedge clock);
            panel_buttons <= '0;
            latency++;
            @(negedge clock);
        end
        if (!activate_elevator) begin
            timeout_count++;
            $display("Timeout: activate_elevator never rose after a single car call");
        end else begin
            compare_value("activate latency", latency, 3);
            compare_value("direction_selector", direction_selector, 1);
        end

        // Ride to the call and wait for its light to clear
        steps = 0;
        while (!(panel_button_lights == '0 && !elevator_moving &&
                 current_floor_state == 4'd5) && steps < 60) begin
            run_cycle(1'b0);
            @(negedge clock);
            steps++;
        end
        if (steps >= 60) begin
            timeout_count++;
            $display("Timeout: car did not stop at floor code 5 with its light cleared");
        end

        // Mixed random traffic, the model checks every cycle
        for (int c = 0; c < 3000; c++) begin
            run_cycle(1'b1);
        end

        @(negedge clock);
        $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 error_count, timeout_count, UUT.props.assert_failures);
        if (error_count == 0 && timeout_count == 0 && UUT.props.assert_failures == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
